// File: common/write_guard_pkg.sv
/* Sizes, AXI channel field types, response codes, trip cause encoding
   and table index types for the AXI4 write guard */
package write_guard_pkg;

  // Table capacities
  localparam int unsigned MaxUniqIds = 4;
  localparam int unsigned MaxWrTxns  = 8;

  // Channel field widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned CntWidth  = 8;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [CntWidth-1:0]  cnt_t;

  // AXI B response codes
  typedef logic [1:0] resp_t;
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlverr = 2'b10;

  // Index into the head-tail table and into the linked data table
  typedef logic [$clog2(MaxUniqIds)-1:0] ht_idx_t;
  typedef logic [$clog2(MaxWrTxns)-1:0]  ld_idx_t;

  // Reason the guard tripped
  typedef enum logic [2:0] {
    NONE,
    AW_STALL,
    W_STALL,
    B_STALL,
    UNKNOWN_ID
  } trip_cause_t;

endpackage

// File: common/guard_lookup_if.sv
/* Push and pop port between the guard control and the outstanding-ID queue */
`timescale 1ns/10ps

interface guard_lookup_if import write_guard_pkg::*; ();
  // Push of an accepted AW
  logic  push_valid;
  logic  push_gnt;
  id_t   push_id;
  addr_t push_addr;
  // Pop on a B response, result is combinational
  logic  pop_valid;
  logic  pop_hit;
  id_t   pop_id;
  addr_t pop_addr;
  logic  empty;

  modport ctrl (
    output push_valid, push_id, push_addr, pop_valid, pop_id,
    input  push_gnt, pop_hit, pop_addr, empty
  );

  modport queue (
    input  push_valid, push_id, push_addr, pop_valid, pop_id,
    output push_gnt, pop_hit, pop_addr, empty
  );
endinterface

// File: common/guard_hs_if.sv
/* Subordinate-side AW, W and B handshake bits as seen by the guard */
`timescale 1ns/10ps

interface guard_hs_if ();
  logic aw_valid;
  logic aw_ready;
  logic w_valid;
  logic w_ready;
  logic b_valid;
  logic b_ready;

  modport gate (
    output aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready
  );

  modport mon (
    input aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready
  );
endinterface

// File: write_guard/id_queue.sv
/* Per-ID linked-list queue of outstanding writes, built from a head-tail
   table and a linked data table holding the write addresses */
`timescale 1ns/10ps

module id_queue import write_guard_pkg::*; (
  input logic           clk_i,
  input logic           rst_ni,
  guard_lookup_if.queue lk
);
  // Head-tail table, one entry per ID in flight
  id_t     [MaxUniqIds-1:0] ht_id_q, ht_id_d;
  ld_idx_t [MaxUniqIds-1:0] ht_head_q, ht_head_d;
  ld_idx_t [MaxUniqIds-1:0] ht_tail_q, ht_tail_d;
  logic    [MaxUniqIds-1:0] ht_free_q, ht_free_d;
  // Linked data table
  addr_t   [MaxWrTxns-1:0]  ld_addr_q, ld_addr_d;
  ld_idx_t [MaxWrTxns-1:0]  ld_next_q, ld_next_d;
  logic    [MaxWrTxns-1:0]  ld_free_q, ld_free_d;

  logic    pop_match, push_match, pop_fire, pop_last, push_fire, ht_avail;
  ht_idx_t pop_idx, push_idx, ht_free_idx, new_ht;
  ld_idx_t ld_free_idx, pop_head, push_slot;

  // ID match and lowest-free search, scanning downwards so the lowest index wins
  always_comb begin
    pop_match   = 1'b0;
    push_match  = 1'b0;
    pop_idx     = '0;
    push_idx    = '0;
    ht_free_idx = '0;
    ld_free_idx = '0;
    for (int i = MaxUniqIds - 1; i >= 0; i--) begin
      if (!ht_free_q[i] && (ht_id_q[i] == lk.pop_id)) begin
        pop_match = 1'b1;
        pop_idx   = ht_idx_t'(i);
      end
      if (!ht_free_q[i] && (ht_id_q[i] == lk.push_id)) begin
        push_match = 1'b1;
        push_idx   = ht_idx_t'(i);
      end
      if (ht_free_q[i]) begin
        ht_free_idx = ht_idx_t'(i);
      end
    end
    for (int i = MaxWrTxns - 1; i >= 0; i--) begin
      if (ld_free_q[i]) begin
        ld_free_idx = ld_idx_t'(i);
      end
    end
  end

  assign pop_head    = ht_head_q[pop_idx];
  assign pop_last    = (pop_head == ht_tail_q[pop_idx]);
  assign pop_fire    = lk.pop_valid && pop_match;
  assign lk.pop_hit  = pop_match;
  assign lk.pop_addr = ld_addr_q[pop_head];
  assign lk.empty    = &ld_free_q;

  // A new ID also needs a head-tail entry, possibly the one popped right now
  assign ht_avail    = (|ht_free_q) || push_match || (pop_fire && pop_last);
  assign lk.push_gnt = ((|ld_free_q) || pop_fire) && ht_avail;
  assign push_fire   = lk.push_valid && lk.push_gnt;

  // A slot freed by a pop is handed straight to the push
  assign push_slot = pop_fire ? pop_head : ld_free_idx;
  assign new_ht    = (pop_fire && pop_last) ? pop_idx : ht_free_idx;

  always_comb begin
    ht_id_d   = ht_id_q;
    ht_head_d = ht_head_q;
    ht_tail_d = ht_tail_q;
    ht_free_d = ht_free_q;
    ld_addr_d = ld_addr_q;
    ld_next_d = ld_next_q;
    ld_free_d = ld_free_q;
    if (pop_fire) begin
      ld_free_d[pop_head] = 1'b1;
      if (pop_last) begin
        ht_free_d[pop_idx] = 1'b1;
      end else begin
        ht_head_d[pop_idx] = ld_next_q[pop_head];
      end
    end
    if (push_fire) begin
      ld_addr_d[push_slot] = lk.push_addr;
      ld_next_d[push_slot] = '0;
      ld_free_d[push_slot] = 1'b0;
      if (push_match && !(pop_fire && pop_last && (pop_idx == push_idx))) begin
        // Append behind the current tail of this ID
        ld_next_d[ht_tail_q[push_idx]] = push_slot;
        ht_tail_d[push_idx]            = push_slot;
      end else begin
        ht_id_d[new_ht]   = lk.push_id;
        ht_head_d[new_ht] = push_slot;
        ht_tail_d[new_ht] = push_slot;
        ht_free_d[new_ht] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ht_free_q <= '1;
      ld_free_q <= '1;
    end else begin
      ht_free_q <= ht_free_d;
      ld_free_q <= ld_free_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ht_id_q   <= ht_id_d;
    ht_head_q <= ht_head_d;
    ht_tail_q <= ht_tail_d;
    ld_addr_q <= ld_addr_d;
    ld_next_q <= ld_next_d;
  end

endmodule

// File: write_guard/stall_monitor.sv
/* Stall counters for the AW, W and B phases, checked against runtime budgets */
`timescale 1ns/10ps

module stall_monitor import write_guard_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        guard_en_i,
  guard_hs_if.mon     hs,
  input  logic        outstanding_i,
  input  cnt_t        budget_aw_i,
  input  cnt_t        budget_w_i,
  input  cnt_t        budget_b_i,
  output logic        timeout_o,
  output trip_cause_t timeout_cause_o
);
  cnt_t aw_cnt_q, w_cnt_q, b_cnt_q;
  logic aw_hs, w_hs, b_hs;
  logic aw_hit, w_hit, b_hit;

  // Saturating count step
  function automatic cnt_t step(cnt_t cnt, logic clr, logic inc);
    if (clr) return '0;
    if (inc && (cnt != '1)) return cnt + cnt_t'(1);
    return cnt;
  endfunction

  // A zero budget disables the check
  function automatic logic at_budget(cnt_t cnt, cnt_t budget);
    return (budget != '0) && (cnt == budget);
  endfunction

  assign aw_hs = hs.aw_valid && hs.aw_ready;
  assign w_hs  = hs.w_valid && hs.w_ready;
  assign b_hs  = hs.b_valid && hs.b_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_cnt_q <= '0;
      w_cnt_q  <= '0;
      b_cnt_q  <= '0;
    end else if (guard_en_i) begin
      aw_cnt_q <= step(aw_cnt_q, aw_hs, hs.aw_valid && !hs.aw_ready);
      w_cnt_q  <= step(w_cnt_q, w_hs, hs.w_valid && !hs.w_ready);
      // Time since the last W or B progress while writes are pending
      b_cnt_q  <= step(b_cnt_q, w_hs || b_hs, outstanding_i);
    end
  end

  assign aw_hit    = at_budget(aw_cnt_q, budget_aw_i);
  assign w_hit     = at_budget(w_cnt_q, budget_w_i);
  assign b_hit     = at_budget(b_cnt_q, budget_b_i);
  assign timeout_o = aw_hit || w_hit || b_hit;

  always_comb begin
    timeout_cause_o = NONE;
    if (aw_hit) timeout_cause_o = AW_STALL;
    else if (w_hit) timeout_cause_o = W_STALL;
    else if (b_hit) timeout_cause_o = B_STALL;
  end

endmodule

// File: write_guard/channel_gate.sv
/* AW, W and B forwarding with queue-full back-pressure, and the one-entry
   SLVERR responder that answers AWs once the guard has tripped */
`timescale 1ns/10ps

module channel_gate import write_guard_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  mgr_aw_valid_i,
  output logic  mgr_aw_ready_o,
  input  id_t   mgr_aw_id_i,
  input  addr_t mgr_aw_addr_i,
  input  logic  mgr_w_valid_i,
  output logic  mgr_w_ready_o,
  input  data_t mgr_w_data_i,
  input  logic  mgr_w_last_i,
  output logic  mgr_b_valid_o,
  input  logic  mgr_b_ready_i,
  output id_t   mgr_b_id_o,
  output resp_t mgr_b_resp_o,
  output logic  slv_aw_valid_o,
  input  logic  slv_aw_ready_i,
  output id_t   slv_aw_id_o,
  output addr_t slv_aw_addr_o,
  output logic  slv_w_valid_o,
  input  logic  slv_w_ready_i,
  output data_t slv_w_data_o,
  output logic  slv_w_last_o,
  input  logic  slv_b_valid_i,
  output logic  slv_b_ready_o,
  input  id_t   slv_b_id_i,
  input  resp_t slv_b_resp_i,
  input  logic  guard_en_i,
  input  logic  tripped_i,
  input  logic  aw_allow_i,
  guard_hs_if.gate hs
);
  logic blocked, err_accept, err_valid_q;
  id_t  err_id_q;

  assign blocked    = guard_en_i && tripped_i;
  assign err_accept = blocked && mgr_aw_valid_i && !err_valid_q;

  always_comb begin
    slv_aw_valid_o = mgr_aw_valid_i;
    mgr_aw_ready_o = slv_aw_ready_i;
    slv_w_valid_o  = mgr_w_valid_i;
    mgr_w_ready_o  = slv_w_ready_i;
    mgr_b_valid_o  = slv_b_valid_i;
    slv_b_ready_o  = mgr_b_ready_i;
    mgr_b_id_o     = slv_b_id_i;
    mgr_b_resp_o   = slv_b_resp_i;
    if (blocked) begin
      // Cut the subordinate off, sink W beats and drain its late responses
      slv_aw_valid_o = 1'b0;
      mgr_aw_ready_o = !err_valid_q;
      slv_w_valid_o  = 1'b0;
      mgr_w_ready_o  = 1'b1;
      mgr_b_valid_o  = err_valid_q;
      slv_b_ready_o  = 1'b1;
      mgr_b_id_o     = err_id_q;
      mgr_b_resp_o   = RespSlverr;
    end else if (guard_en_i) begin
      // Hold AW back while the ID queue has no room
      slv_aw_valid_o = mgr_aw_valid_i && aw_allow_i;
      mgr_aw_ready_o = slv_aw_ready_i && aw_allow_i;
    end
  end

  assign slv_aw_id_o   = mgr_aw_id_i;
  assign slv_aw_addr_o = mgr_aw_addr_i;
  assign slv_w_data_o  = mgr_w_data_i;
  assign slv_w_last_o  = mgr_w_last_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_q <= 1'b0;
    end else if (err_accept) begin
      err_valid_q <= 1'b1;
    end else if (err_valid_q && mgr_b_ready_i) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_accept) begin
      err_id_q <= mgr_aw_id_i;
    end
  end

  assign hs.aw_valid = slv_aw_valid_o;
  assign hs.aw_ready = slv_aw_ready_i;
  assign hs.w_valid  = slv_w_valid_o;
  assign hs.w_ready  = slv_w_ready_i;
  assign hs.b_valid  = slv_b_valid_i;
  assign hs.b_ready  = slv_b_ready_o;

endmodule

// File: write_guard/guard_ctrl.sv
/* Guard control: queue push and pop, trip latch with cause and ID capture,
   and the registered completion report */
`timescale 1ns/10ps

module guard_ctrl import write_guard_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          guard_en_i,
  input  id_t           mgr_aw_id_i,
  input  addr_t         mgr_aw_addr_i,
  input  id_t           slv_b_id_i,
  input  resp_t         slv_b_resp_i,
  guard_hs_if.mon       hs,
  guard_lookup_if.ctrl  lk,
  input  logic          timeout_i,
  input  trip_cause_t   timeout_cause_i,
  output logic          tripped_o,
  output logic          aw_allow_o,
  output logic          outstanding_o,
  output logic          irq_o,
  output logic          reset_req_o,
  output trip_cause_t   trip_cause_o,
  output id_t           trip_id_o,
  output logic          cmpl_valid_o,
  output id_t           cmpl_id_o,
  output addr_t         cmpl_addr_o,
  output resp_t         cmpl_resp_o
);
  logic        active, aw_fwd, b_fwd, b_known, unknown_id, trip_now;
  logic        tripped_q, cmpl_valid_q;
  trip_cause_t cause_q;
  id_t         trip_id_q, cmpl_id_q;
  addr_t       cmpl_addr_q;
  resp_t       cmpl_resp_q;

  // Only handshakes that really reach the subordinate are tracked
  assign active     = guard_en_i && !tripped_q;
  assign aw_fwd     = active && hs.aw_valid && hs.aw_ready;
  assign b_fwd      = active && hs.b_valid && hs.b_ready;
  assign b_known    = b_fwd && lk.pop_hit;
  assign unknown_id = b_fwd && !lk.pop_hit;
  assign trip_now   = unknown_id || (active && timeout_i);

  assign lk.push_valid = aw_fwd;
  assign lk.push_id    = mgr_aw_id_i;
  assign lk.push_addr  = mgr_aw_addr_i;
  assign lk.pop_valid  = b_fwd;
  assign lk.pop_id     = slv_b_id_i;

  assign aw_allow_o    = lk.push_gnt;
  assign outstanding_o = !lk.empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tripped_q    <= 1'b0;
      cause_q      <= NONE;
      trip_id_q    <= '0;
      cmpl_valid_q <= 1'b0;
    end else begin
      cmpl_valid_q <= b_known;
      if (trip_now) begin
        tripped_q <= 1'b1;
        // A stray response outranks a stall seen in the same cycle
        cause_q   <= unknown_id ? UNKNOWN_ID : timeout_cause_i;
        if (unknown_id) begin
          trip_id_q <= slv_b_id_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_known) begin
      cmpl_id_q   <= slv_b_id_i;
      cmpl_addr_q <= lk.pop_addr;
      cmpl_resp_q <= slv_b_resp_i;
    end
  end

  assign tripped_o    = tripped_q;
  assign irq_o        = tripped_q;
  assign reset_req_o  = tripped_q;
  assign trip_cause_o = cause_q;
  assign trip_id_o    = trip_id_q;
  assign cmpl_valid_o = cmpl_valid_q;
  assign cmpl_id_o    = cmpl_id_q;
  assign cmpl_addr_o  = cmpl_addr_q;
  assign cmpl_resp_o  = cmpl_resp_q;

endmodule

// File: hdl/axi_write_guard.sv
/* AXI4 write-channel guard top level with plain manager and subordinate ports */
`timescale 1ns/10ps

module axi_write_guard import write_guard_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        guard_en_i,
  input  logic        mgr_aw_valid_i,
  output logic        mgr_aw_ready_o,
  input  id_t         mgr_aw_id_i,
  input  addr_t       mgr_aw_addr_i,
  input  logic        mgr_w_valid_i,
  output logic        mgr_w_ready_o,
  input  data_t       mgr_w_data_i,
  input  logic        mgr_w_last_i,
  output logic        mgr_b_valid_o,
  input  logic        mgr_b_ready_i,
  output id_t         mgr_b_id_o,
  output resp_t       mgr_b_resp_o,
  output logic        slv_aw_valid_o,
  input  logic        slv_aw_ready_i,
  output id_t         slv_aw_id_o,
  output addr_t       slv_aw_addr_o,
  output logic        slv_w_valid_o,
  input  logic        slv_w_ready_i,
  output data_t       slv_w_data_o,
  output logic        slv_w_last_o,
  input  logic        slv_b_valid_i,
  output logic        slv_b_ready_o,
  input  id_t         slv_b_id_i,
  input  resp_t       slv_b_resp_i,
  input  cnt_t        budget_aw_i,
  input  cnt_t        budget_w_i,
  input  cnt_t        budget_b_i,
  output logic        irq_o,
  output logic        reset_req_o,
  output trip_cause_t trip_cause_o,
  output id_t         trip_id_o,
  output logic        cmpl_valid_o,
  output id_t         cmpl_id_o,
  output addr_t       cmpl_addr_o,
  output resp_t       cmpl_resp_o
);
  logic        tripped, aw_allow, outstanding, timeout;
  trip_cause_t timeout_cause;

  guard_lookup_if lk_if ();
  guard_hs_if     hs_if ();

  guard_ctrl i_ctrl (
    .clk_i, .rst_ni, .guard_en_i, .mgr_aw_id_i, .mgr_aw_addr_i,
    .slv_b_id_i, .slv_b_resp_i,
    .hs              (hs_if.mon),
    .lk              (lk_if.ctrl),
    .timeout_i       (timeout),
    .timeout_cause_i (timeout_cause),
    .tripped_o       (tripped),
    .aw_allow_o      (aw_allow),
    .outstanding_o   (outstanding),
    .irq_o, .reset_req_o, .trip_cause_o, .trip_id_o,
    .cmpl_valid_o, .cmpl_id_o, .cmpl_addr_o, .cmpl_resp_o
  );

  id_queue i_queue (
    .clk_i, .rst_ni,
    .lk (lk_if.queue)
  );

  stall_monitor i_monitor (
    .clk_i, .rst_ni, .guard_en_i,
    .hs              (hs_if.mon),
    .outstanding_i   (outstanding),
    .budget_aw_i, .budget_w_i, .budget_b_i,
    .timeout_o       (timeout),
    .timeout_cause_o (timeout_cause)
  );

  // Channel ports share their names with the top level
  channel_gate i_gate (
    .tripped_i  (tripped),
    .aw_allow_i (aw_allow),
    .hs         (hs_if.gate),
    .*
  );

endmodule

// File: bench/wg_model.svh
/* Reference model of the write guard with per-ID expected address queues,
   completion and error-response bookkeeping, and the per-cycle checks */
`ifndef WG_MODEL_SVH
`define WG_MODEL_SVH

// Expected addresses per ID, oldest first
addr_t exp_q [16][$];
id_t   err_q [$];
logic  cmpl_due, tripped_exp, aw_taken, w_taken, b_taken;
id_t   due_id;
addr_t due_addr;
resp_t due_resp;
int    test_errors, aw_count, cmpl_count, err_count;

task automatic check(input logic ok, input string msg);
  assert (ok) else begin
    $display("Mismatch at %0d ns: %s", $time, msg);
    test_errors++;
  end
endtask

function automatic int pending_writes();
  int n;
  n = 0;
  for (int i = 0; i < 16; i++) n += exp_q[i].size();
  return n;
endfunction

// Sampled at the falling edge, where all DUT outputs are settled
task automatic observe();
  logic aw_room;
  aw_taken = mgr_aw_valid_i && mgr_aw_ready_o;
  w_taken  = mgr_w_valid_i && mgr_w_ready_o;
  b_taken  = slv_b_valid_i && slv_b_ready_o;
  if (!rst_ni) return;
  check(cmpl_valid_o == cmpl_due, "completion valid");
  if (cmpl_due) begin
    check(cmpl_id_o == due_id && cmpl_addr_o == due_addr && cmpl_resp_o == due_resp,
          "completion id, address or response");
    cmpl_count++;
  end
  cmpl_due = 1'b0;
  check(allow_trip || !irq_o, "unexpected trip");
  if (allow_trip && irq_o) tripped_exp = 1'b1;
  if (tripped_exp) begin
    check(!slv_aw_valid_o && !slv_w_valid_o, "subordinate valid after trip");
    if (aw_taken) err_q.push_back(mgr_aw_id_i);
    if (mgr_b_valid_o && mgr_b_ready_i) begin
      check(err_q.size() > 0 && mgr_b_id_o == err_q[0], "error response id");
      check(mgr_b_resp_o == RespSlverr, "error response code");
      if (err_q.size() > 0) void'(err_q.pop_front());
      err_count++;
    end
    return;
  end
  check(slv_aw_id_o == mgr_aw_id_i && slv_aw_addr_o == mgr_aw_addr_i, "AW payload");
  check(slv_w_valid_o == mgr_w_valid_i && mgr_w_ready_o == slv_w_ready_i, "W handshake");
  check(slv_w_data_o == mgr_w_data_i && slv_w_last_o == mgr_w_last_i, "W payload");
  check(mgr_b_valid_o == slv_b_valid_i && slv_b_ready_o == mgr_b_ready_i, "B handshake");
  check(mgr_b_id_o == slv_b_id_i && mgr_b_resp_o == slv_b_resp_i, "B payload");
  if (guard_en_i) begin
    // A response leaving in this cycle frees a slot for one more write
    aw_room = (pending_writes() < MaxWrTxns) ||
              (b_taken && exp_q[slv_b_id_i].size() > 0);
    check(slv_aw_valid_o == (mgr_aw_valid_i && aw_room), "AW valid against queue room");
    check(mgr_aw_ready_o == (slv_aw_ready_i && aw_room), "AW ready against queue room");
  end else begin
    check(slv_aw_valid_o == mgr_aw_valid_i && mgr_aw_ready_o == slv_aw_ready_i, "AW bypass");
  end
  if (slv_aw_valid_o && slv_aw_ready_i) begin
    exp_q[slv_aw_id_o].push_back(slv_aw_addr_o);
    aw_count++;
  end
  if (b_taken && exp_q[slv_b_id_i].size() > 0) begin
    // A known ID makes a report due in the next cycle when the guard is active
    cmpl_due = guard_en_i;
    due_id   = slv_b_id_i;
    due_addr = exp_q[slv_b_id_i].pop_front();
    due_resp = slv_b_resp_i;
  end
endtask

`endif

// File: bench/tb_axi_write_guard.sv
/* Testbench for the AXI4 write guard with clock, reset, random manager and
   subordinate, and the bypass, tracking, queue-full, unknown-ID and stall tests */
`timescale 1ns/10ps

module tb_axi_write_guard import write_guard_pkg::*; ();
  logic clk_i, rst_ni, guard_en_i;
  logic mgr_aw_valid_i, mgr_aw_ready_o, mgr_w_valid_i, mgr_w_ready_o, mgr_w_last_i;
  logic mgr_b_valid_o, mgr_b_ready_i, slv_aw_valid_o, slv_aw_ready_i;
  logic slv_w_valid_o, slv_w_ready_i, slv_w_last_o, slv_b_valid_i, slv_b_ready_o;
  logic irq_o, reset_req_o, cmpl_valid_o;
  id_t  mgr_aw_id_i, mgr_b_id_o, slv_aw_id_o, slv_b_id_i, trip_id_o, cmpl_id_o;
  addr_t mgr_aw_addr_i, slv_aw_addr_o, cmpl_addr_o;
  data_t mgr_w_data_i, slv_w_data_o;
  resp_t mgr_b_resp_o, slv_b_resp_i, cmpl_resp_o;
  cnt_t  budget_aw_i, budget_w_i, budget_b_i;
  trip_cause_t trip_cause_o;
  // Stimulus knobs with rates in percent
  logic issue_aw, allow_trip, stray_b;
  int   aw_pct, rdy_pct, b_pct, b_rdy_pct, errors, failed, cycles;

  `include "wg_model.svh"

  axi_write_guard dut_i (.*);

  always #50 clk_i = !clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= 4000) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic drive();
    id_t cand[$];
    if (!mgr_aw_valid_i || aw_taken) begin
      mgr_aw_valid_i <= issue_aw && ($urandom_range(99) < aw_pct);
      mgr_aw_id_i    <= id_t'($urandom_range(3));
      mgr_aw_addr_i  <= addr_t'($urandom);
    end
    if (!mgr_w_valid_i || w_taken) begin
      mgr_w_valid_i <= $urandom_range(1);
      mgr_w_data_i  <= data_t'($urandom);
    end
    slv_aw_ready_i <= ($urandom_range(99) < rdy_pct);
    slv_w_ready_i  <= ($urandom_range(99) < rdy_pct);
    mgr_b_ready_i  <= ($urandom_range(99) < b_rdy_pct);
    if (stray_b) begin
      slv_b_valid_i <= 1'b1;
      slv_b_id_i    <= 4'h5;
      slv_b_resp_i  <= RespOkay;
      stray_b = 1'b0;
    end else if (!slv_b_valid_i || b_taken) begin
      // Any outstanding ID may answer, so responses reorder across IDs
      for (int i = 0; i < 4; i++) if (exp_q[i].size() > 0) cand.push_back(id_t'(i));
      slv_b_valid_i <= (cand.size() > 0) && ($urandom_range(99) < b_pct);
      if (cand.size() > 0) slv_b_id_i <= cand[$urandom_range(cand.size() - 1)];
      slv_b_resp_i <= $urandom_range(1) ? RespSlverr : RespOkay;
    end
  endtask

  task automatic step(input int n);
    repeat (n) begin
      @(negedge clk_i);
      observe();
      @(posedge clk_i);
      drive();
    end
  endtask

  task automatic restart(input logic en, input cnt_t aw_budget);
    issue_aw = 1'b0;
    b_pct = 0;
    @(posedge clk_i);
    rst_ni <= 1'b0;
    guard_en_i <= en;
    budget_aw_i <= aw_budget;
    step(5);
    for (int i = 0; i < 16; i++) exp_q[i].delete();
    err_q.delete();
    {cmpl_due, tripped_exp, allow_trip} = '0;
    {test_errors, aw_count, cmpl_count, err_count} = '0;
    check(!irq_o && !reset_req_o && !cmpl_valid_o && trip_cause_o == NONE, "reset values");
    rst_ni <= 1'b1;
  endtask

  task automatic finish_test(input string name);
    $display("Test %-10s %s, %0d errors", name, test_errors ? "failed" : "passed", test_errors);
    errors += test_errors;
    if (test_errors) failed++;
  endtask

  initial begin
    void'($urandom(54844));
    {clk_i, rst_ni, guard_en_i, mgr_aw_valid_i, mgr_w_valid_i, mgr_b_ready_i} = '0;
    {slv_aw_ready_i, slv_w_ready_i, slv_b_valid_i, stray_b} = '0;
    {mgr_aw_id_i, mgr_aw_addr_i, mgr_w_data_i, slv_b_id_i, slv_b_resp_i} = '0;
    mgr_w_last_i = 1'b1;
    {budget_aw_i, budget_w_i, budget_b_i} = '0;
    {errors, failed, cycles, aw_pct, rdy_pct, b_rdy_pct} = '0;
    // Bypass with long stalls and small budgets that must stay silent
    restart(1'b0, 8'd3);
    budget_w_i <= 8'd3;
    budget_b_i <= 8'd3;
    {issue_aw, aw_pct, rdy_pct, b_pct, b_rdy_pct} = {1'b1, 32'd60, 32'd20, 32'd30, 32'd30};
    step(300);
    finish_test("bypass");
    restart(1'b1, 8'd0);
    budget_w_i <= 8'd0;
    budget_b_i <= 8'd0;
    {issue_aw, aw_pct, rdy_pct, b_pct, b_rdy_pct} = {1'b1, 32'd50, 32'd60, 32'd40, 32'd70};
    step(600);
    issue_aw = 1'b0;
    for (int n = 0; n < 300 && (pending_writes() > 0 || cmpl_due); n++) step(1);
    check(pending_writes() == 0 && cmpl_count == aw_count && aw_count > 0, "completion count");
    finish_test("tracking");
    // Full queue where one response frees exactly one slot
    restart(1'b1, 8'd0);
    {issue_aw, aw_pct, rdy_pct, b_pct, b_rdy_pct} = {1'b1, 32'd100, 32'd100, 32'd0, 32'd100};
    step(40);
    check(aw_count == MaxWrTxns, "AW count with full queue");
    b_pct = 100;
    step(1);
    b_pct = 0;
    step(20);
    check(aw_count == MaxWrTxns + 1, "AW count after one response");
    finish_test("queue_full");
    restart(1'b1, 8'd0);
    {issue_aw, aw_pct, rdy_pct, b_pct, b_rdy_pct} = {1'b1, 32'd100, 32'd100, 32'd0, 32'd100};
    step(4);
    issue_aw = 1'b0;
    step(3);
    allow_trip = 1'b1;
    stray_b = 1'b1;
    for (int n = 0; n < 20 && !tripped_exp; n++) step(1);
    if (!tripped_exp) begin
      $display("No trip after a response with an unknown ID");
      test_errors++;
    end
    check(irq_o && reset_req_o, "irq or reset request");
    check(trip_cause_o == UNKNOWN_ID && trip_id_o == 4'h5, "trip cause or ID");
    finish_test("unknown_id");
    // AW stall against a budget of 6 and the SLVERR answers that follow
    restart(1'b1, 8'd6);
    allow_trip = 1'b1;
    {issue_aw, aw_pct, rdy_pct, b_pct, b_rdy_pct} = {1'b1, 32'd100, 32'd0, 32'd0, 32'd50};
    for (int n = 0; n < 40 && !tripped_exp; n++) step(1);
    if (!tripped_exp) begin
      $display("No trip while AW ready was held low");
      test_errors++;
    end
    check(trip_cause_o == AW_STALL, "trip cause after AW stall");
    aw_pct = 50;
    step(60);
    issue_aw = 1'b0;
    for (int n = 0; n < 60 && (err_q.size() > 0 || mgr_aw_valid_i); n++) step(1);
    check(err_q.size() == 0 && err_count > 1, "error responses after trip");
    finish_test("stall");
    $display("Summary: 5 tests, %0d failed, %0d errors", failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: axi_write_guard.f
+incdir+bench
common/write_guard_pkg.sv
common/guard_lookup_if.sv
common/guard_hs_if.sv
write_guard/id_queue.sv
write_guard/stall_monitor.sv
write_guard/channel_gate.sv
write_guard/guard_ctrl.sv
hdl/axi_write_guard.sv
bench/tb_axi_write_guard.sv

// File: Bender.yml
package:
  name: axi_write_guard

sources:
  - common/write_guard_pkg.sv
  - common/guard_lookup_if.sv
  - common/guard_hs_if.sv
  - write_guard/id_queue.sv
  - write_guard/stall_monitor.sv
  - write_guard/channel_gate.sv
  - write_guard/guard_ctrl.sv
  - hdl/axi_write_guard.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_axi_write_guard.sv
